// File: decode_stage.f
common/riscv_pkg.sv
decode/main_decoder.sv
decode/alu_decoder.sv
decode/imm_gen.sv
logic/reg_file.sv
logic/hazard_unit.sv
decode/decode_stage.sv
dv/decode_stage_tb.sv

// File: Makefile
SIM := obj_dir/Vdecode_stage_tb

all: run

$(SIM): decode_stage.f $(shell cat decode_stage.f)
	verilator --binary --timing --top-module decode_stage_tb -f decode_stage.f -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^No errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: dv/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb import riscv_pkg::*; ();

    localparam int NUM_TESTS = 160;             // Issued cycles, rounded up

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        jump;
        logic        branch;
        logic        jalr;
        logic        alu_src;
        logic        op1_pc;
        logic        rs1_used;
        logic        rs2_used;
        result_src_e result_src;
        alu_ctrl_e   alu_ctrl;
        logic [XLEN-1:0] imm;
    } dec_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic                  instr_valid;
    logic                  stall;
    logic                  flush;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  load_use_stall;
    logic                  ex_valid;
    logic                  ex_reg_write;
    result_src_e           ex_result_src;
    logic                  ex_mem_write;
    logic                  ex_jump;
    logic                  ex_branch;
    logic                  ex_jalr;
    logic                  ex_alu_src;
    logic                  ex_op1_pc;
    alu_ctrl_e             ex_alu_ctrl;
    logic [XLEN-1:0]       ex_rs1_data;
    logic [XLEN-1:0]       ex_rs2_data;
    logic [XLEN-1:0]       ex_imm;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [REG_ADDR_W-1:0] ex_rs1;
    logic [REG_ADDR_W-1:0] ex_rs2;
    logic [XLEN-1:0]       ex_pc;

    integer                seed;
    int                    checks;
    int                    value_errors;
    int                    other_errors;
    int                    stalls_seen;

    // Model of the ID/EX register and the register file
    logic [XLEN-1:0]       shadow [NUM_REGS];
    logic                  m_valid;
    dec_t                  m_exp;
    logic [XLEN-1:0]       m_rs1_data;
    logic [XLEN-1:0]       m_rs2_data;
    logic [REG_ADDR_W-1:0] m_rd;
    logic [REG_ADDR_W-1:0] m_rs1;
    logic [REG_ADDR_W-1:0] m_rs2;
    logic [XLEN-1:0]       m_pc;

    decode_stage uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .pc             (pc),
        .instr_valid    (instr_valid),
        .stall          (stall),
        .flush          (flush),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .load_use_stall (load_use_stall),
        .ex_valid       (ex_valid),
        .ex_reg_write   (ex_reg_write),
        .ex_result_src  (ex_result_src),
        .ex_mem_write   (ex_mem_write),
        .ex_jump        (ex_jump),
        .ex_branch      (ex_branch),
        .ex_jalr        (ex_jalr),
        .ex_alu_src     (ex_alu_src),
        .ex_op1_pc      (ex_op1_pc),
        .ex_alu_ctrl    (ex_alu_ctrl),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_rd          (ex_rd),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_pc          (ex_pc)
    );

    always #5 clk = ~clk;

    function automatic alu_ctrl_e funct_op(input logic [2:0] f3, input logic b30,
                                           input logic reg_form);
        case (f3)
            3'd0: return (reg_form && b30) ? SUB : ADD;
            3'd1: return SLL;
            3'd2: return SLT;
            3'd3: return SLTU;
            3'd4: return XOR;
            3'd5: return b30 ? SRA : SRL;
            3'd6: return OR;
            default: return AND;
        endcase
    endfunction

    function automatic dec_t decode_ref(input logic [XLEN-1:0] ins);
        dec_t            d;
        logic [8:0]      ctl;                   // reg_write mem_write jump branch jalr
        logic [XLEN-1:0] imm_s;                 // alu_src op1_pc rs1_used rs2_used
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] imm_u;
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        d = '0;
        d.imm = {{20{ins[31]}}, ins[31:20]};    // I format unless decoded otherwise
        ctl = 9'b000000000;
        case (ins[6:0])
            OP: begin
                ctl = 9'b100000011;
                d.alu_ctrl = funct_op(ins[14:12], ins[30], 1'b1);
            end
            LOAD: begin
                ctl = 9'b100001010;
                d.result_src = RES_MEM;
            end
            OP_IMM: begin
                ctl = 9'b100001010;
                d.alu_ctrl = funct_op(ins[14:12], ins[30], 1'b0);
            end
            STORE: begin
                ctl = 9'b010001011;
                d.imm = imm_s;
            end
            BRANCH: begin
                ctl = 9'b000100011;
                d.alu_ctrl = SUB;
                d.imm = imm_b;
            end
            JALR: ctl = 9'b101011010;
            JAL: begin
                ctl = 9'b101001000;
                d.result_src = RES_PC4;
                d.imm = imm_j;
            end
            LUI: begin
                ctl = 9'b100001000;
                d.imm = imm_u;
            end
            AUIPC: begin
                ctl = 9'b100001100;
                d.imm = imm_u;
            end
            default: ctl = 9'b000000000;        // Unknown opcode is a NOP
        endcase
        {d.reg_write, d.mem_write, d.jump, d.branch, d.jalr,
         d.alu_src, d.op1_pc, d.rs1_used, d.rs2_used} = ctl;
        return d;
    endfunction

    function automatic logic [XLEN-1:0] read_shadow(input logic [REG_ADDR_W-1:0] a);
        if (a == '0)
            return '0;
        else if (wb_we && wb_rd == a)
            return wb_data;                     // Same-cycle write is visible
        else
            return shadow[a];
    endfunction

    function automatic logic stall_expected();
        dec_t nd;
        nd = decode_ref(instr);
        return m_valid && m_exp.result_src == RES_MEM && m_rd != '0 && instr_valid &&
               ((nd.rs1_used && instr[19:15] == m_rd) || (nd.rs2_used && instr[24:20] == m_rd));
    endfunction

    function automatic logic [XLEN-1:0] encode(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [2:0] f3, input logic [6:0] top);
        return {top, rs2, rs1, f3, rd, op};
    endfunction

    task automatic check_ctrl(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_alu(input alu_ctrl_e got, input alu_ctrl_e exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_src(input result_src_e got, input result_src_e exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Model update on the same edge the DUT registers
    always @(posedge clk) begin
        dec_t nd;
        logic hazard;
        nd = decode_ref(instr);
        hazard = stall_expected();
        if (!rst_n) begin
            m_valid = 1'b0;
            m_exp = '0;
            for (int i = 0; i < NUM_REGS; i++)
                shadow[i] = '0;
        end else begin
            if (flush) begin
                m_valid = 1'b0;
                m_exp = '0;
            end else if (!stall) begin
                m_valid = instr_valid && !hazard;
                m_exp = m_valid ? nd : '0;
                m_rs1_data = read_shadow(instr[19:15]);
                m_rs2_data = read_shadow(instr[24:20]);
                m_rd = instr[11:7];
                m_rs1 = instr[19:15];
                m_rs2 = instr[24:20];
                m_pc = pc;
            end
            if (wb_we && wb_rd != '0)
                shadow[wb_rd] = wb_data;
        end
    end

    // Compare mid-cycle, where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_ctrl(load_use_stall, stall_expected(), "load_use_stall");
            if (load_use_stall && stall_expected())
                stalls_seen++;
            if (ex_valid !== m_valid) begin
                other_errors++;
                if (m_valid)
                    $display("At %0d ns an accepted instruction is missing from EX", $time);
                else
                    $display("At %0d ns EX shows a valid instruction that was never accepted",
                             $time);
            end
            check_ctrl(ex_reg_write, m_exp.reg_write, "ex_reg_write");
            check_ctrl(ex_mem_write, m_exp.mem_write, "ex_mem_write");
            check_ctrl(ex_jump, m_exp.jump, "ex_jump");
            check_ctrl(ex_branch, m_exp.branch, "ex_branch");
            check_ctrl(ex_jalr, m_exp.jalr, "ex_jalr");
            check_ctrl(ex_alu_src, m_exp.alu_src, "ex_alu_src");
            check_ctrl(ex_op1_pc, m_exp.op1_pc, "ex_op1_pc");
            check_src(ex_result_src, m_exp.result_src, "ex_result_src");
            check_alu(ex_alu_ctrl, m_exp.alu_ctrl, "ex_alu_ctrl");
            if (m_valid) begin                  // Datapath only matters for real work
                check_word(ex_imm, m_exp.imm, "ex_imm");
                check_word(ex_rs1_data, m_rs1_data, "ex_rs1_data");
                check_word(ex_rs2_data, m_rs2_data, "ex_rs2_data");
                check_word(ex_pc, m_pc, "ex_pc");
                check_word({17'd0, ex_rd, ex_rs1, ex_rs2}, {17'd0, m_rd, m_rs1, m_rs2},
                           "ex_rd/ex_rs1/ex_rs2");
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input logic [XLEN-1:0] ins, input logic valid);
        logic [XLEN-1:0] rnd;
        rnd = $random(seed);
        instr = ins;
        pc = {rnd[XLEN-1:2], 2'b00};
        instr_valid = valid;
        next_cycle();
    endtask

    initial begin
        logic [XLEN-1:0] rnd;
        logic [XLEN-1:0] ins;
        opcode_e         ops [9];
        seed = 32'h24da8cf6;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        stalls_seen = 0;
        ops = '{OP, LOAD, OP_IMM, STORE, BRANCH, JALR, JAL, LUI, AUIPC};
        rst_n = 1'b0;
        instr = '0;
        pc = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Every opcode with random fields, both immediate signs, random writebacks
        for (int k = 0; k < 9; k++) begin
            for (int n = 0; n < 8; n++) begin
                rnd = $random(seed);
                wb_we = rnd[0];
                wb_rd = rnd[5:1];
                wb_data = $random(seed);
                ins = $random(seed);
                ins[31] = n[0];
                ins[6:0] = ops[k];
                issue(ins, 1'b1);
            end
        end
        wb_we = 1'b0;

        // All funct3 values with bit 30 low and high
        for (int f = 0; f < 16; f++) begin
            issue(encode(OP, 5'd1, 5'd2, 5'd3, f[2:0], {1'b0, f[3], 5'd0}), 1'b1);
            issue(encode(OP_IMM, 5'd1, 5'd2, 5'd3, f[2:0], {1'b0, f[3], 5'd0}), 1'b1);
        end

        // Register file writes with same-cycle reads
        for (int n = 0; n < 8; n++) begin
            rnd = $random(seed);
            wb_we = 1'b1;
            wb_rd = rnd[4:0];
            wb_data = $random(seed);
            issue(encode(OP, 5'd4, rnd[4:0], rnd[9:5], 3'd0, 7'd0), 1'b1);
        end
        wb_we = 1'b0;
        for (int r = 0; r < 32; r += 2)
            issue(encode(OP, 5'd4, r[4:0], 5'(r + 1), 3'd0, 7'd0), 1'b1);
        wb_we = 1'b1;
        wb_rd = 5'd0;
        wb_data = 32'hdeadbeef;
        issue(encode(OP, 5'd4, 5'd0, 5'd0, 3'd0, 7'd0), 1'b1);
        wb_we = 1'b0;
        issue(encode(OP, 5'd4, 5'd0, 5'd0, 3'd0, 7'd0), 1'b1);

        // Load-use on rs1, then on store data
        ins = encode(OP, 5'd6, 5'd5, 5'd7, 3'd0, 7'd0);
        issue(encode(LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0), 1'b1);
        issue(ins, 1'b1);
        issue(ins, 1'b1);                       // Fetch holds it for one more cycle
        ins = encode(STORE, 5'd0, 5'd1, 5'd9, 3'd2, 7'd0);
        issue(encode(LOAD, 5'd9, 5'd2, 5'd0, 3'd2, 7'd0), 1'b1);
        issue(ins, 1'b1);
        issue(ins, 1'b1);
        issue(encode(LOAD, 5'd9, 5'd2, 5'd0, 3'd2, 7'd0), 1'b1);
        issue(encode(OP_IMM, 5'd3, 5'd1, 5'd9, 3'd0, 7'd0), 1'b1);  // rs2 field unused
        issue(encode(LOAD, 5'd0, 5'd2, 5'd0, 3'd2, 7'd0), 1'b1);
        issue(encode(OP, 5'd3, 5'd0, 5'd0, 3'd0, 7'd0), 1'b1);      // x0 never stalls

        // Hold under stall, then flush
        issue(encode(JAL, 5'd1, 5'd3, 5'd8, 3'd5, 7'h55), 1'b1);
        stall = 1'b1;
        for (int n = 0; n < 4; n++)
            issue($random(seed), 1'b1);
        stall = 1'b0;
        flush = 1'b1;
        issue(encode(LOAD, 5'd2, 5'd1, 5'd0, 3'd2, 7'd0), 1'b1);
        flush = 1'b0;
        issue(encode(STORE, 5'd0, 5'd1, 5'd2, 3'd2, 7'd0), 1'b1);
        stall = 1'b1;
        flush = 1'b1;
        issue(encode(OP, 5'd3, 5'd1, 5'd2, 3'd0, 7'd0), 1'b1);
        stall = 1'b0;
        flush = 1'b0;

        // Unknown opcodes and an idle fetch
        issue(encode(7'h7f, 5'd3, 5'd1, 5'd2, 3'd0, 7'h20), 1'b1);
        issue(encode(7'h00, 5'd3, 5'd1, 5'd2, 3'd0, 7'h20), 1'b1);
        issue(encode(OP, 5'd3, 5'd1, 5'd2, 3'd0, 7'h20), 1'b0);
        next_cycle();

        if (stalls_seen < 2) begin
            other_errors++;
            $display("The load-use stall was seen only %0d times", stalls_seen);
        end
        $display("Checks %0d, value mismatches %0d, other failures %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 4 + 100) @(posedge clk);
        $display("Timeout after %0d cycles, the stimulus never finished", NUM_TESTS * 4 + 100);
        $display("Errors found");
        $finish;
    end

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [XLEN-1:0]       instr,
    input  logic [XLEN-1:0]       pc,
    input  logic                  instr_valid,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,

    output logic                  load_use_stall,
    output logic                  ex_valid,
    output logic                  ex_reg_write,
    output result_src_e           ex_result_src,
    output logic                  ex_mem_write,
    output logic                  ex_jump,
    output logic                  ex_branch,
    output logic                  ex_jalr,
    output logic                  ex_alu_src,
    output logic                  ex_op1_pc,
    output alu_ctrl_e             ex_alu_ctrl,
    output logic [XLEN-1:0]       ex_rs1_data,
    output logic [XLEN-1:0]       ex_rs2_data,
    output logic [XLEN-1:0]       ex_imm,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [REG_ADDR_W-1:0] ex_rs1,
    output logic [REG_ADDR_W-1:0] ex_rs2,
    output logic [XLEN-1:0]       ex_pc
);

    opcode_e         opcode;
    logic            jump_d;
    logic            branch_d;
    result_src_e     result_src;
    logic            mem_write;
    logic            alu_src;
    imm_src_e        imm_src;
    logic            reg_write;
    alu_op_e         alu_op;
    logic            jalr;
    logic            op1_pc;
    logic            rs1_signal;
    logic            rs2_signal;
    alu_ctrl_e       alu_ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            ex_load;
    logic            id_live;

    assign opcode  = opcode_e'(instr[6:0]);
    assign ex_load = ex_valid && (ex_result_src == RES_MEM);
    assign id_live = instr_valid && !load_use_stall;    // Bubble otherwise

    main_decoder u_main_decoder (
        .opcode     (opcode),
        .jump_d     (jump_d),
        .branch_d   (branch_d),
        .result_src (result_src),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .imm_src    (imm_src),
        .reg_write  (reg_write),
        .alu_op     (alu_op),
        .jalr       (jalr),
        .op1_pc     (op1_pc),
        .rs1_signal (rs1_signal),
        .rs2_signal (rs2_signal)
    );

    alu_decoder u_alu_decoder (
        .alu_op    (alu_op),
        .funct3    (instr[14:12]),
        .funct7_b5 (instr[30]),
        .op_r_type (opcode == OP),      // SUB only for register form
        .alu_ctrl  (alu_ctrl)
    );

    imm_gen u_imm_gen (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .we       (wb_we),
        .rd_addr  (wb_rd),
        .wd       (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    hazard_unit u_hazard_unit (
        .rs1            (instr[19:15]),
        .rs2            (instr[24:20]),
        .rs1_used       (rs1_signal && instr_valid),
        .rs2_used       (rs2_signal && instr_valid),
        .ex_rd          (ex_rd),
        .ex_load        (ex_load),
        .load_use_stall (load_use_stall)
    );

    // ID/EX control fields
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_result_src <= RES_ALU;
            ex_mem_write  <= 1'b0;
            ex_jump       <= 1'b0;
            ex_branch     <= 1'b0;
            ex_jalr       <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_op1_pc     <= 1'b0;
            ex_alu_ctrl   <= ADD;
        end else if (flush) begin               // Flush wins over stall
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_result_src <= RES_ALU;
            ex_mem_write  <= 1'b0;
            ex_jump       <= 1'b0;
            ex_branch     <= 1'b0;
            ex_jalr       <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_op1_pc     <= 1'b0;
            ex_alu_ctrl   <= ADD;
        end else if (!stall) begin
            ex_valid      <= id_live;
            ex_reg_write  <= id_live && reg_write;
            ex_result_src <= id_live ? result_src : RES_ALU;
            ex_mem_write  <= id_live && mem_write;
            ex_jump       <= id_live && jump_d;
            ex_branch     <= id_live && branch_d;
            ex_jalr       <= id_live && jalr;
            ex_alu_src    <= id_live && alu_src;
            ex_op1_pc     <= id_live && op1_pc;
            ex_alu_ctrl   <= id_live ? alu_ctrl : ADD;
        end
    end

    // Datapath fields are don't-care in a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rs1_data <= '0;
            ex_rs2_data <= '0;
            ex_imm      <= '0;
            ex_rd       <= '0;
            ex_rs1      <= '0;
            ex_rs2      <= '0;
            ex_pc       <= '0;
        end else if (!stall) begin
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_imm      <= imm;
            ex_rd       <= instr[11:7];
            ex_rs1      <= instr[19:15];
            ex_rs2      <= instr[24:20];
            ex_pc       <= pc;
        end
    end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import riscv_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  rs1_used,
    input  logic                  rs2_used,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic                  ex_load,

    output logic                  load_use_stall
);

    logic load_pending;
    logic rs1_hit;
    logic rs2_hit;

    // Load result is not ready until after memory
    assign load_pending = ex_load && (ex_rd != '0);

    assign rs1_hit = rs1_used && (rs1 == ex_rd);
    assign rs2_hit = rs2_used && (rs2 == ex_rd);

    assign load_use_stall = load_pending && (rs1_hit || rs2_hit);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [XLEN-1:0]       wd,

    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= wd;
        end
    end

    always_comb begin
        if (rs1_addr == '0)
            rs1_data = '0;
        else if (we && (rd_addr == rs1_addr))
            rs1_data = wd;                  // Write-through
        else
            rs1_data = regs[rs1_addr];

        if (rs2_addr == '0)
            rs2_data = '0;
        else if (we && (rd_addr == rs2_addr))
            rs2_data = wd;
        else
            rs2_data = regs[rs2_addr];
    end

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/10ps

module imm_gen import riscv_pkg::*; (
    input  logic [XLEN-1:0] instr,
    input  imm_src_e        imm_src,

    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (imm_src)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};     // Halfword aligned
            IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};                   // Upper 20 bits
            default: imm = '0;
        endcase
    end

endmodule

// File: decode/alu_decoder.sv
`timescale 1ns/10ps

module alu_decoder import riscv_pkg::*; (
    input  alu_op_e    alu_op,
    input  logic [2:0] funct3,
    input  logic       funct7_b5,
    input  logic       op_r_type,

    output alu_ctrl_e  alu_ctrl
);

    always_comb begin
        alu_ctrl = ADD;
        case (alu_op)
            ALU_ADD: alu_ctrl = ADD;
            ALU_SUB: alu_ctrl = SUB;
            ALU_FUNCT: begin
                case (funct3)
                    3'b000: alu_ctrl = (op_r_type && funct7_b5) ? SUB : ADD; // No SUBI
                    3'b001: alu_ctrl = SLL;
                    3'b010: alu_ctrl = SLT;
                    3'b011: alu_ctrl = SLTU;
                    3'b100: alu_ctrl = XOR;
                    3'b101: alu_ctrl = funct7_b5 ? SRA : SRL; // Same for SRAI
                    3'b110: alu_ctrl = OR;
                    3'b111: alu_ctrl = AND;
                    default: alu_ctrl = ADD;
                endcase
            end
            default: alu_ctrl = ADD;
        endcase
    end

endmodule

// File: decode/main_decoder.sv
`timescale 1ns/10ps

module main_decoder import riscv_pkg::*; (
    input  opcode_e     opcode,

    output logic        jump_d,
    output logic        branch_d,
    output result_src_e result_src,
    output logic        mem_write,
    output logic        alu_src,
    output imm_src_e    imm_src,
    output logic        reg_write,
    output alu_op_e     alu_op,
    output logic        jalr,
    output logic        op1_pc,
    output logic        rs1_signal,
    output logic        rs2_signal
);

    always_comb begin
        jump_d     = 1'b0;              // Everything off unless decoded
        branch_d   = 1'b0;
        result_src = RES_ALU;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        imm_src    = IMM_I;
        reg_write  = 1'b0;
        alu_op     = ALU_ADD;
        jalr       = 1'b0;
        op1_pc     = 1'b0;
        rs1_signal = 1'b0;
        rs2_signal = 1'b0;

        case (opcode)
            OP: begin
                reg_write  = 1'b1;
                alu_op     = ALU_FUNCT; // Funct fields decide
                rs1_signal = 1'b1;
                rs2_signal = 1'b1;
            end
            LOAD: begin
                result_src = RES_MEM;   // Data from memory
                alu_src    = 1'b1;
                imm_src    = IMM_I;
                reg_write  = 1'b1;
                alu_op     = ALU_ADD;   // Address = rs1 + imm
                rs1_signal = 1'b1;
            end
            OP_IMM: begin
                alu_src    = 1'b1;
                imm_src    = IMM_I;
                reg_write  = 1'b1;
                alu_op     = ALU_FUNCT;
                rs1_signal = 1'b1;
            end
            STORE: begin
                mem_write  = 1'b1;
                alu_src    = 1'b1;
                imm_src    = IMM_S;
                rs1_signal = 1'b1;
                rs2_signal = 1'b1;      // Store data
            end
            BRANCH: begin
                branch_d   = 1'b1;
                imm_src    = IMM_B;
                alu_op     = ALU_SUB;   // Compare by subtraction
                rs1_signal = 1'b1;
                rs2_signal = 1'b1;
            end
            JALR: begin
                jump_d     = 1'b1;
                alu_src    = 1'b1;
                imm_src    = IMM_I;
                reg_write  = 1'b1;
                jalr       = 1'b1;      // Target is rs1 + imm
                rs1_signal = 1'b1;
            end
            JAL: begin
                jump_d     = 1'b1;
                result_src = RES_PC4;   // rd gets pc + 4
                alu_src    = 1'b1;
                imm_src    = IMM_J;
                reg_write  = 1'b1;
            end
            LUI: begin
                alu_src    = 1'b1;
                imm_src    = IMM_U;
                reg_write  = 1'b1;      // x0 + imm in execute
            end
            AUIPC: begin
                alu_src    = 1'b1;
                imm_src    = IMM_U;
                reg_write  = 1'b1;
                op1_pc     = 1'b1;      // Operand A is the pc
            end
            default: begin
                // Unknown opcode behaves as a NOP
            end
        endcase
    end

endmodule

// File: common/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef enum logic [6:0] {
        OP     = 7'd51,                 // R-type arithmetic
        LOAD   = 7'd3,
        OP_IMM = 7'd19,                 // I-type arithmetic
        STORE  = 7'd35,
        BRANCH = 7'd99,
        JALR   = 7'd103,
        JAL    = 7'd111,
        LUI    = 7'd55,
        AUIPC  = 7'd23
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_FUNCT = 3'd2                // funct3/funct7 pick the operation
    } alu_op_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2                  // Link address for jumps
    } result_src_e;

endpackage
